// File: compile.f
hdl/rv_pkg.sv
hdl/rv_decode_if.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
sim/rv_core_properties.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decode_if.sv
  - hdl/rv_fetch.sv
  - hdl/rv_decode.sv
  - hdl/rv_regfile.sv
  - hdl/rv_execute.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_properties.sv
      - sim/rv_core_tb.sv

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int mem_words = 256;
  localparam int test_limit = 300; // Cycles allowed per program
  localparam int num_tests = 6;
  localparam int reset_cycles = 8;
  localparam int watchdog_cycles = num_tests * (test_limit + 8) + reset_cycles + 100;
  localparam logic [31:0] ecall = 32'h0000_0073;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] insn;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;
  logic        halt;
  logic        illegal;

  logic [31:0] imem [mem_words];
  logic [31:0] dmem [mem_words];
  logic [31:0] prog [$];
  int          exp_idx [$];
  logic [31:0] exp_val [$];
  logic [31:0] illegal_pcs [$];
  logic [31:0] exp_illegal [$];
  integer      seed = 32'h9a10182a;
  int          errors;
  int          timeouts;
  int          checks;
  int          next_off;

  rv_core #(
    .p_reset_pc (32'h0)
  ) dut0 (
    .clk          (clk),
    .rst          (rst),
    .o_pc         (pc),
    .i_insn       (insn),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata),
    .o_halt       (halt),
    .o_illegal    (illegal)
  );

  // Zero-latency memories
  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!rst && dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  always @(negedge clk) begin
    if (!rst && illegal) begin
      illegal_pcs.push_back(pc); // Where the flag came up
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] addr;
    addr = 32'(idx * 4);
    return {~addr[15:0], addr[15:0]};
  endfunction

  function automatic logic [31:0] rr_insn(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    rv_pkg::rv_insn_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = rv_pkg::op_reg_reg;
    return w;
  endfunction

  function automatic logic [31:0] imm_insn(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
    rv_pkg::rv_insn_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = op;
    return w;
  endfunction

  function automatic logic [31:0] sw_insn(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    rv_pkg::rv_insn_u w;
    w.s.imm_hi = imm[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = 3'b010;
    w.s.imm_lo = imm[4:0];
    w.s.opcode = rv_pkg::op_store;
    return w;
  endfunction

  function automatic logic [31:0] branch_insn(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    rv_pkg::rv_insn_u w;
    w.b.imm_12   = imm[12];
    w.b.imm_10_5 = imm[10:5];
    w.b.rs2      = rs2;
    w.b.rs1      = rs1;
    w.b.funct3   = f3;
    w.b.imm_4_1  = imm[4:1];
    w.b.imm_11   = imm[11];
    w.b.opcode   = rv_pkg::op_branch;
    return w;
  endfunction

  function automatic logic [31:0] upper_insn(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
    rv_pkg::rv_insn_u w;
    w.u.imm    = imm;
    w.u.rd     = rd;
    w.u.opcode = op;
    return w;
  endfunction

  function automatic logic [31:0] jal_insn(input logic [20:0] imm, input logic [4:0] rd);
    rv_pkg::rv_insn_u w;
    w.j.imm_20    = imm[20];
    w.j.imm_10_1  = imm[10:1];
    w.j.imm_11    = imm[11];
    w.j.imm_19_12 = imm[19:12];
    w.j.rd        = rd;
    w.j.opcode    = rv_pkg::op_jal;
    return w;
  endfunction

  // Branch rule by funct3
  function automatic logic cond_holds(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic start_program();
    prog.delete();
    exp_idx.delete();
    exp_val.delete();
    exp_illegal.delete();
    next_off = 'h100;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800; // ADDI sign-extends its low part
    emit(upper_insn(upper[31:12], rd, rv_pkg::op_lui));
    emit(imm_insn(value[11:0], rd, 3'b000, rd, rv_pkg::op_reg_imm));
  endtask

  task automatic expect_word(input int off, input logic [31:0] value);
    exp_idx.push_back(off / 4);
    exp_val.push_back(value);
  endtask

  task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
    emit(sw_insn(12'(next_off), rs2, 5'd0));
    expect_word(next_off, value);
    next_off += 4;
  endtask

  task automatic run_program(input string name);
    int cycles;
    emit(ecall);
    @(posedge clk);
    rst <= 1'b1;
    for (int idx = 0; idx < mem_words; idx++) begin
      imem[idx] <= (idx < prog.size()) ? prog[idx] : ecall;
      dmem[idx] <= fill_word(idx);
    end
    repeat (2) @(posedge clk);
    illegal_pcs.delete();
    rst <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!halt && cycles < test_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      timeouts++;
      $display("%s: program did not halt within %0d cycles", name, test_limit);
      return;
    end
    checks++;
    if (pc !== 32'(4 * (prog.size() - 1))) begin
      errors++;
      $display("ERR %s o_pc got %h exp %h", name, pc, 32'(4 * (prog.size() - 1)));
    end
    for (int k = 0; k < exp_idx.size(); k++) begin
      checks++;
      if (dmem[exp_idx[k]] !== exp_val[k]) begin
        errors++;
        $display("ERR %s dmem[%h] got %h exp %h", name, 32'(exp_idx[k] * 4),
                 dmem[exp_idx[k]], exp_val[k]);
      end
    end
    checks++;
    if (illegal_pcs.size() != exp_illegal.size()) begin
      errors++;
      $display("%s: illegal flag seen %0d times, expected %0d times", name,
               illegal_pcs.size(), exp_illegal.size());
    end else begin
      for (int k = 0; k < exp_illegal.size(); k++) begin
        if (illegal_pcs[k] !== exp_illegal[k]) begin
          errors++;
          $display("ERR %s o_illegal pc got %h exp %h", name, illegal_pcs[k], exp_illegal[k]);
        end
      end
    end
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] exp);
    emit(imm_insn(imm, 5'd1, f3, 5'd2, rv_pkg::op_reg_imm));
    store_result(5'd2, exp);
  endtask

  task automatic rr_op(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
    emit(rr_insn(f7, 5'd2, 5'd1, f3, 5'd3));
    store_result(5'd3, exp);
  endtask

  task automatic alu_imm_tests();
    logic [31:0] a;
    logic [11:0] imm;
    logic [31:0] simm;
    logic [4:0]  sh;
    start_program();
    for (int round = 0; round < 3; round++) begin
      a    = $random(seed);
      imm  = $random(seed);
      simm = {{20{imm[11]}}, imm};
      sh   = imm[4:0];
      load_const(5'd1, a);
      store_result(5'd1, a); // LUI plus ADDI
      imm_op(3'b000, imm, a + simm);
      imm_op(3'b010, imm, {31'd0, $signed(a) < $signed(simm)});
      imm_op(3'b011, imm, {31'd0, a < simm});
      imm_op(3'b100, imm, a ^ simm);
      imm_op(3'b110, imm, a | simm);
      imm_op(3'b111, imm, a & simm);
      imm_op(3'b001, {7'd0, sh}, a << sh);
      imm_op(3'b101, {7'd0, sh}, a >> sh);
      imm_op(3'b101, {7'b0100000, sh}, $signed(a) >>> sh);
    end
    run_program("alu_imm");
  endtask

  task automatic alu_reg_tests();
    logic [31:0] a;
    logic [31:0] b;
    start_program();
    for (int round = 0; round < 3; round++) begin
      a = $random(seed);
      b = $random(seed);
      load_const(5'd1, a);
      load_const(5'd2, b);
      rr_op(7'd0, 3'b000, a + b);
      rr_op(7'b0100000, 3'b000, a - b);
      rr_op(7'd0, 3'b001, a << b[4:0]);
      rr_op(7'd0, 3'b010, {31'd0, $signed(a) < $signed(b)});
      rr_op(7'd0, 3'b011, {31'd0, a < b});
      rr_op(7'd0, 3'b100, a ^ b);
      rr_op(7'd0, 3'b101, a >> b[4:0]);
      rr_op(7'b0100000, 3'b101, $signed(a) >>> b[4:0]);
      rr_op(7'd0, 3'b110, a | b);
      rr_op(7'd0, 3'b111, a & b);
    end
    run_program("alu_reg");
  endtask

  // Each path loads its own marker into x5 before the common store
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic taken, input logic [11:0] tag);
    emit(branch_insn(13'd12, rs2, rs1, f3));
    emit(imm_insn(tag, 5'd0, 3'b000, 5'd5, rv_pkg::op_reg_imm));
    emit(jal_insn(21'd8, 5'd0));
    emit(imm_insn(tag | 12'h400, 5'd0, 3'b000, 5'd5, rv_pkg::op_reg_imm));
    store_result(5'd5, taken ? 32'(tag | 12'h400) : 32'(tag));
  endtask

  task automatic branch_tests();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  conds [6];
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    start_program();
    a = $random(seed) & 32'h7fff_ffff; // Signed and unsigned order differ
    b = $random(seed) | 32'h8000_0000;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 6; k++) begin
      branch_case(conds[k], 5'd1, 5'd2, cond_holds(conds[k], a, b), 12'(2 * k));
      if (conds[k][2]) begin
        branch_case(conds[k], 5'd2, 5'd1, cond_holds(conds[k], b, a), 12'(2 * k + 1));
      end else begin
        branch_case(conds[k], 5'd1, 5'd1, cond_holds(conds[k], a, a), 12'(2 * k + 1));
      end
    end
    run_program("branch");
  endtask

  task automatic jump_tests();
    logic [31:0] at;
    logic [19:0] up;
    start_program();
    at = 32'(prog.size() * 4);
    emit(jal_insn(21'd12, 5'd1));
    emit(imm_insn(12'h5a5, 5'd0, 3'b000, 5'd7, rv_pkg::op_reg_imm)); // Skipped
    emit(sw_insn(12'h1f0, 5'd7, 5'd0));
    expect_word('h1f0, fill_word('h1f0 / 4));
    store_result(5'd1, at + 4);
    up = $random(seed);
    at = 32'(prog.size() * 4);
    emit(upper_insn(up, 5'd3, rv_pkg::op_auipc));
    store_result(5'd3, at + {up, 12'd0});
    at = 32'(prog.size() * 4);
    emit(upper_insn(20'd0, 5'd4, rv_pkg::op_auipc));
    emit(imm_insn(12'd17, 5'd4, 3'b000, 5'd6, rv_pkg::op_jalr)); // Odd target loses bit 0
    emit(imm_insn(12'h5a5, 5'd0, 3'b000, 5'd7, rv_pkg::op_reg_imm));
    emit(sw_insn(12'h1f4, 5'd7, 5'd0));
    expect_word('h1f4, fill_word('h1f4 / 4));
    store_result(5'd6, at + 8);
    run_program("jump");
  endtask

  task automatic mem_tests();
    logic [31:0] a;
    logic [31:0] b;
    start_program();
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    emit(sw_insn(12'h1c0, 5'd1, 5'd0));
    expect_word('h1c0, a);
    emit(imm_insn(12'h1c0, 5'd0, 3'b010, 5'd2, rv_pkg::op_load));
    store_result(5'd2, a);
    load_const(5'd8, 32'h200);
    load_const(5'd3, b);
    emit(sw_insn(12'd8, 5'd3, 5'd8)); // Base plus offset
    expect_word('h208, b);
    emit(imm_insn(12'd8, 5'd8, 3'b010, 5'd9, rv_pkg::op_load));
    store_result(5'd9, b);
    emit(upper_insn(20'habcde, 5'd0, rv_pkg::op_lui));
    emit(imm_insn(12'h123, 5'd0, 3'b000, 5'd0, rv_pkg::op_reg_imm));
    emit(imm_insn(12'h1c0, 5'd0, 3'b010, 5'd0, rv_pkg::op_load));
    store_result(5'd0, 32'd0);
    run_program("load_store");
  endtask

  task automatic halt_illegal_tests();
    logic [31:0] v;
    start_program();
    v = $random(seed);
    load_const(5'd5, v);
    load_const(5'd9, 32'h33);
    exp_illegal.push_back(32'(prog.size() * 4));
    emit(imm_insn(12'h0ff, 5'd1, 3'b000, 5'd5, 7'b0001011)); // Custom-0 opcode
    store_result(5'd5, v);
    exp_illegal.push_back(32'(prog.size() * 4));
    emit(imm_insn(12'h1c2, 5'd0, 3'b010, 5'd9, rv_pkg::op_load));
    store_result(5'd9, 32'h33);
    run_program("halt_illegal");
    repeat (3) @(negedge clk);
    checks++;
    if (!halt) begin
      errors++;
      $display("halt_illegal: halt dropped while sitting on ECALL");
    end
    if (pc !== 32'(4 * (prog.size() - 1))) begin
      errors++;
      $display("ERR halt_illegal o_pc got %h exp %h", pc, 32'(4 * (prog.size() - 1)));
    end
  endtask

  initial begin
    rst      = 1'b1;
    errors   = 0;
    timeouts = 0;
    checks   = 0;
    for (int idx = 0; idx < mem_words; idx++) begin
      imem[idx] = ecall;
      dmem[idx] = fill_word(idx);
    end
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    alu_imm_tests();
    alu_reg_tests();
    branch_tests();
    jump_tests();
    mem_tests();
    halt_illegal_tests();
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, dut0.props0.fail_count);
    if (errors == 0 && timeouts == 0 && dut0.props0.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 40);
    $display("Watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts + 1, dut0.props0.fail_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties (
  input logic                    clk,
  input logic                    rst,
  input logic [rv_pkg::xlen-1:0] i_pc,
  input logic [rv_pkg::xlen-1:0] i_dmem_addr,
  input logic                    i_dmem_we,
  input logic                    i_halt,
  input logic                    i_illegal
);

  int fail_count = 0; // Failed assertion attempts

  pc_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("PC %h is not word aligned", i_pc);
    end

  store_aligned: assert property (@(posedge clk) disable iff (rst)
    i_dmem_we |-> (i_dmem_addr[1:0] == 2'b00))
    else begin
      fail_count++;
      $error("Store issued to unaligned address %h", i_dmem_addr);
    end

  // Illegal instructions never reach memory
  store_not_illegal: assert property (@(posedge clk) disable iff (rst)
    !(i_dmem_we && i_illegal))
    else begin
      fail_count++;
      $error("Store and illegal flag high in the same cycle");
    end

  halt_holds_pc: assert property (@(posedge clk) disable iff (rst) i_halt |=> $stable(i_pc))
    else begin
      fail_count++;
      $error("PC moved while halted");
    end

endmodule

bind rv_core rv_core_properties props0 (
  .clk         (clk),
  .rst         (rst),
  .i_pc        (o_pc),
  .i_dmem_addr (o_dmem_addr),
  .i_dmem_we   (o_dmem_we),
  .i_halt      (o_halt),
  .i_illegal   (o_illegal)
);

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] p_reset_pc = '0,
  parameter int                      p_num_regs = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::xlen-1:0] o_pc,
  input  logic [rv_pkg::xlen-1:0] i_insn,
  output logic [rv_pkg::xlen-1:0] o_dmem_addr,
  output logic [rv_pkg::xlen-1:0] o_dmem_wdata,
  output logic                    o_dmem_we,
  input  logic [rv_pkg::xlen-1:0] i_dmem_rdata,
  output logic                    o_halt,
  output logic                    o_illegal
);

  logic                    redirect;
  logic [rv_pkg::xlen-1:0] target;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] rd_data;
  logic                    rd_we;

  rv_decode_if dec_if ();

  assign o_halt = dec_if.is_halt;

  rv_fetch #(
    .p_reset_pc (p_reset_pc)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .i_redirect (redirect),
    .i_target   (target),
    .i_halt     (dec_if.is_halt),
    .o_pc       (o_pc)
  );

  rv_decode u_decode (
    .i_insn (i_insn),
    .dec    (dec_if.dec)
  );

  rv_regfile #(
    .p_num_regs (p_num_regs)
  ) u_regfile (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec_if.exe),
    .i_rd_data  (rd_data),
    .i_we       (rd_we),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .dec          (dec_if.exe),
    .i_pc         (o_pc),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_rd_data    (rd_data),
    .o_we         (rd_we),
    .o_redirect   (redirect),
    .o_target     (target),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_illegal    (o_illegal)
  );

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  rv_decode_if.exe                dec,
  input  logic [rv_pkg::xlen-1:0] i_pc,
  input  logic [rv_pkg::xlen-1:0] i_rs1_data,
  input  logic [rv_pkg::xlen-1:0] i_rs2_data,
  input  logic [rv_pkg::xlen-1:0] i_dmem_rdata,
  output logic [rv_pkg::xlen-1:0] o_rd_data,
  output logic                    o_we,
  output logic                    o_redirect,
  output logic [rv_pkg::xlen-1:0] o_target,
  output logic [rv_pkg::xlen-1:0] o_dmem_addr,
  output logic [rv_pkg::xlen-1:0] o_dmem_wdata,
  output logic                    o_dmem_we,
  output logic                    o_illegal
);

  localparam int shamt_w = $clog2(rv_pkg::xlen);

  logic [rv_pkg::xlen-1:0] alu_b;
  logic [shamt_w-1:0]      shamt;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] pc_plus_imm;
  logic                    lt_signed;
  logic                    lt_unsigned;
  logic                    branch_taken;
  logic                    misaligned;
  logic                    illegal;

  assign alu_b = dec.use_imm ? dec.imm : i_rs2_data;
  assign shamt = alu_b[shamt_w-1:0]; // Low five bits only

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:  alu_result = i_rs1_data + alu_b;
      rv_pkg::alu_sub:  alu_result = i_rs1_data - alu_b;
      rv_pkg::alu_sll:  alu_result = i_rs1_data << shamt;
      rv_pkg::alu_slt:  alu_result = rv_pkg::xlen'($signed(i_rs1_data) < $signed(alu_b));
      rv_pkg::alu_sltu: alu_result = rv_pkg::xlen'(i_rs1_data < alu_b);
      rv_pkg::alu_xor:  alu_result = i_rs1_data ^ alu_b;
      rv_pkg::alu_srl:  alu_result = i_rs1_data >> shamt;
      rv_pkg::alu_sra:  alu_result = $unsigned($signed(i_rs1_data) >>> shamt);
      rv_pkg::alu_or:   alu_result = i_rs1_data | alu_b;
      default:          alu_result = i_rs1_data & alu_b;
    endcase
  end

  assign lt_signed   = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_unsigned = i_rs1_data < i_rs2_data;

  // funct3 bit 0 inverts the base condition
  always_comb begin
    case (dec.funct3[2:1])
      2'b00:   branch_taken = (i_rs1_data == i_rs2_data) ^ dec.funct3[0];
      2'b10:   branch_taken = lt_signed ^ dec.funct3[0];
      2'b11:   branch_taken = lt_unsigned ^ dec.funct3[0];
      default: branch_taken = 1'b0;
    endcase
  end

  assign pc_plus4    = i_pc + rv_pkg::xlen'(4);
  assign pc_plus_imm = i_pc + dec.imm; // Branch, JAL and AUIPC

  // Memory address comes out of the ALU as rs1 + imm
  assign misaligned = (dec.is_load || dec.is_store) && (alu_result[1:0] != 2'b00);
  assign illegal    = dec.illegal || misaligned;

  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = i_rs2_data;
  assign o_dmem_we    = dec.is_store && !illegal;
  assign o_illegal    = illegal;

  assign o_redirect = !illegal && (dec.is_jal || dec.is_jalr || (dec.is_branch && branch_taken));
  assign o_target   = dec.is_jalr ? {alu_result[rv_pkg::xlen-1:1], 1'b0} : pc_plus_imm;

  always_comb begin
    case (dec.wb_sel)
      rv_pkg::wb_load:        o_rd_data = i_dmem_rdata;
      rv_pkg::wb_pc_plus4:    o_rd_data = pc_plus4; // Link value
      rv_pkg::wb_imm_upper:   o_rd_data = dec.imm;
      rv_pkg::wb_pc_plus_imm: o_rd_data = pc_plus_imm;
      default:                o_rd_data = alu_result;
    endcase
  end

  assign o_we = dec.reg_write && !illegal;

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile #(
  parameter int p_num_regs = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  rv_decode_if.exe                dec,
  input  logic [rv_pkg::xlen-1:0] i_rd_data,
  input  logic                    i_we,
  output logic [rv_pkg::xlen-1:0] o_rs1_data,
  output logic [rv_pkg::xlen-1:0] o_rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [p_num_regs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int idx = 0; idx < p_num_regs; idx++) begin
        regs[idx] <= '0;
      end
    end else if (i_we && (dec.rd != '0) && (int'(dec.rd) < p_num_regs)) begin
      regs[dec.rd] <= i_rd_data;
    end
  end

  // x0 and indices beyond a reduced file read as zero
  always_comb begin
    o_rs1_data = '0;
    o_rs2_data = '0;
    if ((dec.rs1 != '0) && (int'(dec.rs1) < p_num_regs)) begin
      o_rs1_data = regs[dec.rs1];
    end
    if ((dec.rs2 != '0) && (int'(dec.rs2) < p_num_regs)) begin
      o_rs2_data = regs[dec.rs2];
    end
  end

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic [rv_pkg::xlen-1:0] i_insn,
  rv_decode_if.dec                dec
);

  localparam logic [6:0] f7_alt = 7'b0100000; // SUB and SRA/SRAI

  rv_pkg::rv_insn_u        insn;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [2:0]              funct3;
  logic [6:0]              funct7;

  // Shared by register-immediate and register-register forms
  function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  op = rv_pkg::alu_sll;
      3'b010:  op = rv_pkg::alu_slt;
      3'b011:  op = rv_pkg::alu_sltu;
      3'b100:  op = rv_pkg::alu_xor;
      3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  op = rv_pkg::alu_or;
      default: op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign insn   = i_insn;
  assign funct3 = insn.r.funct3;
  assign funct7 = insn.r.funct7;

  assign imm_i = {{(rv_pkg::xlen-12){insn.i.imm[11]}}, insn.i.imm};
  assign imm_s = {{(rv_pkg::xlen-12){insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
  assign imm_b = {{(rv_pkg::xlen-12){insn.b.imm_12}}, insn.b.imm_11, insn.b.imm_10_5,
                  insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm, 12'b0};
  assign imm_j = {{(rv_pkg::xlen-20){insn.j.imm_20}}, insn.j.imm_19_12, insn.j.imm_11,
                  insn.j.imm_10_1, 1'b0};

  // Register fields sit at the same place in every format
  assign dec.rs1    = insn.r.rs1;
  assign dec.rs2    = insn.r.rs2;
  assign dec.rd     = insn.r.rd;
  assign dec.funct3 = funct3;

  always_comb begin
    dec.imm       = imm_i;
    dec.alu_op    = rv_pkg::alu_add;
    dec.wb_sel    = rv_pkg::wb_alu;
    dec.use_imm   = 1'b0;
    dec.reg_write = 1'b0;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.is_halt   = 1'b0;
    dec.illegal   = 1'b0;

    case (insn.r.opcode)
      rv_pkg::op_lui: begin
        dec.imm       = imm_u;
        dec.wb_sel    = rv_pkg::wb_imm_upper;
        dec.reg_write = 1'b1;
      end
      rv_pkg::op_auipc: begin
        dec.imm       = imm_u;
        dec.wb_sel    = rv_pkg::wb_pc_plus_imm;
        dec.reg_write = 1'b1;
      end
      rv_pkg::op_jal: begin
        dec.imm       = imm_j;
        dec.wb_sel    = rv_pkg::wb_pc_plus4;
        dec.reg_write = 1'b1;
        dec.is_jal    = 1'b1;
      end
      rv_pkg::op_jalr: begin
        dec.use_imm   = 1'b1; // ALU forms rs1 + imm
        dec.wb_sel    = rv_pkg::wb_pc_plus4;
        dec.reg_write = (funct3 == 3'b000);
        dec.is_jalr   = (funct3 == 3'b000);
        dec.illegal   = (funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        dec.imm       = imm_b;
        dec.is_branch = (funct3[2:1] != 2'b01);
        dec.illegal   = (funct3[2:1] == 2'b01); // 010 and 011 unused
      end
      rv_pkg::op_load: begin
        dec.use_imm   = 1'b1;
        dec.wb_sel    = rv_pkg::wb_load;
        dec.reg_write = (funct3 == 3'b010); // LW only
        dec.is_load   = (funct3 == 3'b010);
        dec.illegal   = (funct3 != 3'b010);
      end
      rv_pkg::op_store: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = (funct3 == 3'b010); // SW only
        dec.illegal  = (funct3 != 3'b010);
      end
      rv_pkg::op_reg_imm: begin
        dec.use_imm   = 1'b1;
        dec.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift immediates carry funct7 in the upper bits
        dec.illegal   = ((funct3 == 3'b001) && (funct7 != 7'd0)) ||
                        ((funct3 == 3'b101) && (funct7 != 7'd0) && (funct7 != f7_alt));
        dec.reg_write = !dec.illegal;
      end
      rv_pkg::op_reg_reg: begin
        dec.alu_op    = alu_from_funct3(funct3, funct7[5]);
        dec.illegal   = !((funct7 == 7'd0) ||
                          ((funct7 == f7_alt) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
        dec.reg_write = !dec.illegal;
      end
      rv_pkg::op_misc_mem: begin
        dec.illegal = (funct3 != 3'b000); // FENCE is a no-op
      end
      rv_pkg::op_environ: begin
        dec.is_halt = (i_insn[31:7] == 25'd0); // ECALL
        dec.illegal = (i_insn[31:7] != 25'd0);
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

// File: hdl/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] p_reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_redirect,
  input  logic [rv_pkg::xlen-1:0] i_target,
  input  logic                    i_halt,
  output logic [rv_pkg::xlen-1:0] o_pc
);

  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] pc_plus4;

  assign pc_plus4 = pc + rv_pkg::xlen'(4);

  // Taken branch or jump wins and ECALL freezes the PC
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= p_reset_pc;
    end else if (i_redirect) begin
      pc <= i_target;
    end else if (!i_halt) begin
      pc <= pc_plus4;
    end
  end

  assign o_pc = pc;

endmodule

// File: hdl/rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if;

  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       imm; // Already sign-extended for the format
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::wb_sel_e               wb_sel;
  logic                          use_imm;
  logic                          reg_write;
  logic                          is_branch;
  logic [2:0]                    funct3; // Branch condition
  logic                          is_jal;
  logic                          is_jalr;
  logic                          is_load;
  logic                          is_store;
  logic                          is_halt;
  logic                          illegal;

  modport dec (
    output rs1, rs2, rd, imm, alu_op, wb_sel, use_imm, reg_write, is_branch,
           funct3, is_jal, is_jalr, is_load, is_store, is_halt, illegal
  );

  modport exe (
    input rs1, rs2, rd, imm, alu_op, wb_sel, use_imm, reg_write, is_branch,
          funct3, is_jal, is_jalr, is_load, is_store, is_halt, illegal
  );

endinterface

// File: hdl/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Major opcodes, bits [6:0] of every instruction
  localparam logic [6:0] op_load     = 7'b00_000_11;
  localparam logic [6:0] op_store    = 7'b01_000_11;
  localparam logic [6:0] op_branch   = 7'b11_000_11;
  localparam logic [6:0] op_jalr     = 7'b11_001_11;
  localparam logic [6:0] op_misc_mem = 7'b00_011_11;
  localparam logic [6:0] op_jal      = 7'b11_011_11;
  localparam logic [6:0] op_reg_imm  = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg  = 7'b01_100_11;
  localparam logic [6:0] op_environ  = 7'b11_100_11;
  localparam logic [6:0] op_auipc    = 7'b00_101_11;
  localparam logic [6:0] op_lui      = 7'b01_101_11;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Source of the value written to rd
  typedef enum logic [2:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4,
    wb_imm_upper, // LUI
    wb_pc_plus_imm // AUIPC
  } wb_sel_e;

  // One instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic [6:0]            imm_hi;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_lo;
      logic [6:0]            opcode;
    } s;
    struct packed {
      logic                  imm_12;
      logic [5:0]            imm_10_5;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm_4_1;
      logic                  imm_11;
      logic [6:0]            opcode;
    } b;
    struct packed {
      logic [19:0]           imm;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } u;
    struct packed {
      logic                  imm_20;
      logic [9:0]            imm_10_1;
      logic                  imm_11;
      logic [7:0]            imm_19_12;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } j;
  } rv_insn_u;

endpackage
